//--- files.f
+incdir+testbench
design/spi_pkg.sv
design/display_pkg.sv
design/spi_peripheral.sv
design/spi_register.sv
design/graphics_command.sv
design/display_driver.sv
design/frame_top.sv
testbench/frame_tb.sv

//--- Bender.yml
package:
  name: frame_display

sources:
  - design/spi_pkg.sv
  - design/display_pkg.sv
  - design/spi_peripheral.sv
  - design/spi_register.sv
  - design/graphics_command.sv
  - design/display_driver.sv
  - design/frame_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/frame_tb.sv

//--- testbench/spi_host_tasks.svh
`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

// Mode 0 host, MSB first, SPI clock idles low
task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
        spi_data_in = tx[i];
        repeat (SPI_HALF) @(negedge clock_18MHz_oscillator);
        spi_clock = 1'b1;
        rx[i] = spi_data_out;   // Target changed it on the last falling edge
        repeat (SPI_HALF) @(negedge clock_18MHz_oscillator);
        spi_clock = 1'b0;
    end
endtask

task automatic open_select();
    @(negedge clock_18MHz_oscillator);
    spi_select = 1'b0;
endtask

task automatic close_select();
    repeat (SPI_HALF) @(negedge clock_18MHz_oscillator);
    spi_select = 1'b1;
    spi_data_in = 1'b0;
    repeat (SELECT_GAP) @(negedge clock_18MHz_oscillator);   // Let the target see select high
endtask

// Opcode, then one dummy byte that carries the response back
task automatic read_register(input logic [7:0] opcode, output logic [7:0] rx);
    logic [7:0] unused_rx;
    open_select();
    shift_byte(opcode, unused_rx);
    shift_byte(8'h00, rx);
    close_select();
endtask

// Graphics opcode with two operand bytes, high byte first
task automatic send_command(input logic [7:0] opcode, input logic [15:0] word);
    logic [7:0] unused_rx;
    command_busy = 1'b1;
    open_select();
    shift_byte(opcode, unused_rx);
    shift_byte(word[15:8], unused_rx);
    shift_byte(word[7:0], unused_rx);
    close_select();
    if (opcode == OPCODE_FILL_COLOR) begin
        // Colour sits in the top ten bits
        sent_y = word[15:12];
        sent_cb = word[11:9];
        sent_cr = word[8:6];
    end else begin
        sent_cursor_x = word[15:8];
        sent_cursor_y = word[7:0];
    end
    command_count++;
    command_busy = 1'b0;
endtask

task automatic wait_settled();
    wait (settled);
    @(negedge clock_18MHz_oscillator);
endtask

// Rising vsync closes the frame that was on screen
task automatic wait_frame();
    @(posedge display_vsync);
    @(negedge clock_18MHz_oscillator);
endtask

function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

`endif

//--- testbench/frame_tb.sv
`timescale 1ns/1ns

module frame_tb;

    import spi_pkg::*;
    import display_pkg::*;

    localparam int H_ACTIVE = 16;
    localparam int H_FRONT = 2;
    localparam int H_SYNC = 3;
    localparam int H_BACK = 3;
    localparam int V_ACTIVE = 8;
    localparam int V_FRONT = 1;
    localparam int V_SYNC = 2;
    localparam int V_BACK = 1;
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

    localparam int SPI_HALF = 4;
    localparam int SELECT_GAP = 8;
    localparam int NUM_TESTS = 6;
    localparam int FRAME_CLOCKS = 2 * H_TOTAL * V_TOTAL;
    localparam int BYTE_CLOCKS = 2 * 8 * SPI_HALF;
    localparam int TRANSACTION_CLOCKS = 1 + SPI_HALF + SELECT_GAP;
    // Thirteen bytes in five transactions, then three frames per test
    localparam int WATCHDOG_CLOCKS = 13 * BYTE_CLOCKS + 5 * TRANSACTION_CLOCKS
                                     + NUM_TESTS * 3 * FRAME_CLOCKS + 10;

    logic clock_18MHz_oscillator;
    logic rst = 1'b1;
    logic spi_select = 1'b1;
    logic spi_clock = 1'b0;
    logic spi_data_in = 1'b0;
    logic spi_data_out;
    logic display_clock;
    logic display_hsync;
    logic display_vsync;
    logic [3:0] display_y;
    logic [2:0] display_cb;
    logic [2:0] display_cr;

    int error_count = 0;
    int test_start_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    logic [31:0] rng_state = 32'd88;
    logic past_rst = 1'b0;

    // Reference model, what the host sent and what should be on screen
    logic command_busy = 1'b0;
    int command_count = 0;
    int armed_count = 0;
    int applied_count = 0;
    logic [3:0] sent_y = '0, model_y = '0;
    logic [2:0] sent_cb = '0, model_cb = '0;
    logic [2:0] sent_cr = '0, model_cr = '0;
    logic [7:0] sent_cursor_x = '0, model_cursor_x = '0;
    logic [7:0] sent_cursor_y = '0, model_cursor_y = '0;

    // Position of the pixel shown at the next display clock
    logic locked = 1'b0;
    int h_pos = 0;
    int v_pos = 0;
    int hsync_count = 0;
    logic prev_hsync = 1'b1;
    logic prev_vsync = 1'b1;

    wire settled = !command_busy && (applied_count == command_count);
    wire in_active = (h_pos < H_ACTIVE) && (v_pos < V_ACTIVE);
    wire on_cursor = (h_pos == int'(model_cursor_x)) && (v_pos == int'(model_cursor_y));
    wire hsync_expected = !(h_pos >= H_SYNC_START && h_pos < H_SYNC_START + H_SYNC);
    wire vsync_expected = !(v_pos >= V_SYNC_START && v_pos < V_SYNC_START + V_SYNC);

    `include "spi_host_tasks.svh"

    frame_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) dut (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst(rst),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out),
        .display_clock(display_clock),
        .display_hsync(display_hsync),
        .display_vsync(display_vsync),
        .display_y(display_y),
        .display_cb(display_cb),
        .display_cr(display_cr)
    );

    initial begin
        clock_18MHz_oscillator = 1'b0;
        forever #50 clock_18MHz_oscillator = ~clock_18MHz_oscillator;
    end

    task automatic flag_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] expected);
        error_count++;
        $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, expected, $time);
    endtask

    task automatic flag_failure(input string text);
        error_count++;
        $display("Failure at %0t: %s", $time, text);
    endtask

    task automatic pixel_error(input logic [9:0] got, input logic [9:0] expected,
                               input int x, input int y);
        error_count++;
        $display("** Error: display_y/cb/cr = 0x%h/0x%h/0x%h, expected 0x%h/0x%h/0x%h at pixel %0d,%0d",
                 got[9:6], got[5:3], got[2:0], expected[9:6], expected[5:3], expected[2:0], x, y);
    endtask

    task automatic begin_test();
        test_start_errors = error_count;
    endtask

    task automatic end_test(input string name);
        if (error_count == test_start_errors) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, error_count - test_start_errors);
        end
    endtask

    always @(posedge clock_18MHz_oscillator) past_rst <= rst;

    // Follows the raster, locks once on the first vsync rising edge
    always @(posedge display_clock) begin
        prev_hsync <= display_hsync;
        prev_vsync <= display_vsync;
        if (prev_hsync && !display_hsync) hsync_count <= hsync_count + 1;
        if (!prev_vsync && display_vsync) begin
            if (locked) begin
                assert (hsync_count == V_TOTAL)
                else flag_mismatch("display_hsync pulses per frame", hsync_count, V_TOTAL);
            end
            hsync_count <= 0;
        end
        if (!locked && !prev_vsync && display_vsync) begin
            locked <= 1'b1;
            h_pos <= 1;
            v_pos <= V_SYNC_START + V_SYNC;     // Vsync ends at the start of a line
        end else if (h_pos == H_TOTAL - 1) begin
            h_pos <= 0;
            v_pos <= (v_pos == V_TOTAL - 1) ? 0 : v_pos + 1;
            if (locked && v_pos == V_TOTAL - 1) begin
                applied_count <= armed_count;   // New frame takes what was armed
                model_y <= sent_y;
                model_cb <= sent_cb;
                model_cr <= sent_cr;
                model_cursor_x <= sent_cursor_x;
                model_cursor_y <= sent_cursor_y;
            end
        end else begin
            h_pos <= h_pos + 1;
        end
        if (!display_vsync && !command_busy) armed_count <= command_count;
    end

    reset_check: assert property (@(posedge clock_18MHz_oscillator) past_rst |->
        (display_hsync && display_vsync && !display_clock && !spi_data_out &&
         display_y == '0 && display_cb == '0 && display_cr == '0))
        else flag_failure("outputs left their reset values while reset was applied");

    blank_check: assert property (@(posedge display_clock) disable iff (!locked)
        !in_active |-> (display_y == '0 && display_cb == '0 && display_cr == '0))
        else pixel_error({$sampled(display_y), $sampled(display_cb), $sampled(display_cr)},
                         10'd0, $sampled(h_pos), $sampled(v_pos));

    fill_check: assert property (@(posedge display_clock) disable iff (!locked)
        (in_active && settled && !on_cursor) |->
        (display_y == model_y && display_cb == model_cb && display_cr == model_cr))
        else pixel_error({$sampled(display_y), $sampled(display_cb), $sampled(display_cr)},
                         {$sampled(model_y), $sampled(model_cb), $sampled(model_cr)},
                         $sampled(h_pos), $sampled(v_pos));

    cursor_check: assert property (@(posedge display_clock) disable iff (!locked)
        (in_active && settled && on_cursor) |->
        (display_y == CURSOR_Y && display_cb == CURSOR_CB && display_cr == CURSOR_CR))
        else pixel_error({$sampled(display_y), $sampled(display_cb), $sampled(display_cr)},
                         {CURSOR_Y, CURSOR_CB, CURSOR_CR}, $sampled(h_pos), $sampled(v_pos));

    hsync_check: assert property (@(posedge display_clock) disable iff (!locked)
        display_hsync == hsync_expected)
        else flag_mismatch("display_hsync", $sampled(display_hsync), $sampled(hsync_expected));

    vsync_check: assert property (@(posedge display_clock) disable iff (!locked)
        display_vsync == vsync_expected)
        else flag_mismatch("display_vsync", $sampled(display_vsync), $sampled(vsync_expected));

    initial begin
        repeat (WATCHDOG_CLOCKS) @(posedge clock_18MHz_oscillator);
        $display("Watchdog expired after %0d clocks, a test never finished", WATCHDOG_CLOCKS);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [7:0] rx;
        logic [7:0] spare_rx;
        logic [15:0] word;
        logic [7:0] cx;
        logic [7:0] cy;
        repeat (3) @(negedge clock_18MHz_oscillator);
        rst = 1'b0;

        begin_test();
        assert (display_hsync && display_vsync) else flag_failure("syncs low after reset");
        assert (display_y == '0) else flag_mismatch("display_y", display_y, 0);
        assert (display_cb == '0) else flag_mismatch("display_cb", display_cb, 0);
        assert (display_cr == '0) else flag_mismatch("display_cr", display_cr, 0);
        assert (!spi_data_out) else flag_mismatch("spi_data_out", spi_data_out, 0);
        end_test("reset state");

        begin_test();
        read_register(OPCODE_CHIP_ID, rx);
        assert (rx == CHIP_ID_VALUE) else flag_mismatch("spi_data_out", rx, CHIP_ID_VALUE);
        read_register(OPCODE_VERSION, rx);
        assert (rx == VERSION_VALUE) else flag_mismatch("spi_data_out", rx, VERSION_VALUE);
        end_test("register reads");

        begin_test();
        // Two operand bytes that would repaint the screen if taken as a command
        open_select();
        shift_byte(8'h55, spare_rx);
        shift_byte(8'hFF, rx);
        shift_byte(8'hFF, spare_rx);
        close_select();
        assert (rx == 8'h00) else flag_mismatch("spi_data_out", rx, 8'h00);
        wait_frame();
        wait_frame();   // Whole frame after lock, still the reset picture
        end_test("unclaimed opcode");

        begin_test();
        rng_state = xorshift(rng_state);
        word = rng_state[15:0];
        send_command(OPCODE_FILL_COLOR, word);
        wait_settled();
        wait_frame();
        end_test("fill colour");

        begin_test();
        rng_state = xorshift(rng_state);
        cx = 8'(rng_state % 32'(H_ACTIVE));
        rng_state = xorshift(rng_state);
        cy = 8'(rng_state % 32'(V_ACTIVE));
        send_command(OPCODE_CURSOR_POS, {cx, cy});
        wait_settled();
        wait_frame();
        end_test("cursor position");

        begin_test();
        assert (locked) else flag_failure("raster never locked to a vsync pulse");
        wait_frame();
        wait_frame();
        end_test("sync timing");

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- design/frame_top.sv
`timescale 1ns/1ns

module frame_top #(
    parameter int H_ACTIVE = 256,
    parameter int H_FRONT = 16,
    parameter int H_SYNC = 32,
    parameter int H_BACK = 16,
    parameter int V_ACTIVE = 192,
    parameter int V_FRONT = 4,
    parameter int V_SYNC = 4,
    parameter int V_BACK = 12,
    parameter logic [7:0] CHIP_ID = spi_pkg::CHIP_ID_VALUE,
    parameter logic [7:0] VERSION = spi_pkg::VERSION_VALUE
) (
    input logic clock_18MHz_oscillator,
    input logic rst,

    input logic spi_select,
    input logic spi_clock,
    input logic spi_data_in,
    output logic spi_data_out,

    output logic display_clock,
    output logic display_hsync,
    output logic display_vsync,
    output logic [display_pkg::Y_WIDTH-1:0] display_y,
    output logic [display_pkg::CB_WIDTH-1:0] display_cb,
    output logic [display_pkg::CR_WIDTH-1:0] display_cr
);

    import spi_pkg::*;
    import display_pkg::*;

    logic [7:0] opcode;
    logic opcode_valid;
    logic [7:0] operand;
    logic operand_valid;
    logic [7:0] operand_count;

    logic [7:0] chip_id_response;
    logic chip_id_valid;
    logic [7:0] version_response;
    logic version_valid;
    logic [7:0] response;
    logic response_valid;

    logic command_req;
    logic command_ack;
    command_kind_t command_kind;
    command_word_t command_word;

    // Idle registers drive zero
    assign response = chip_id_response | version_response;
    assign response_valid = chip_id_valid | version_valid;

    spi_peripheral spi_peripheral (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst(rst),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out),
        .opcode(opcode),
        .opcode_valid(opcode_valid),
        .operand(operand),
        .operand_valid(operand_valid),
        .operand_count(operand_count),
        .response(response),
        .response_valid(response_valid)
    );

    spi_register #(
        .REGISTER_OPCODE(OPCODE_CHIP_ID),
        .REGISTER_VALUE(CHIP_ID)
    ) chip_id (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst(rst),
        .opcode(opcode),
        .opcode_valid(opcode_valid),
        .spi_select(spi_select),
        .response(chip_id_response),
        .response_valid(chip_id_valid)
    );

    spi_register #(
        .REGISTER_OPCODE(OPCODE_VERSION),
        .REGISTER_VALUE(VERSION)
    ) version (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst(rst),
        .opcode(opcode),
        .opcode_valid(opcode_valid),
        .spi_select(spi_select),
        .response(version_response),
        .response_valid(version_valid)
    );

    graphics_command graphics_command (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst(rst),
        .opcode(opcode),
        .opcode_valid(opcode_valid),
        .operand(operand),
        .operand_valid(operand_valid),
        .operand_count(operand_count),
        .command_req(command_req),
        .command_ack(command_ack),
        .command_kind(command_kind),
        .command_word(command_word)
    );

    display_driver #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT(H_FRONT),
        .H_SYNC(H_SYNC),
        .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT(V_FRONT),
        .V_SYNC(V_SYNC),
        .V_BACK(V_BACK)
    ) display_driver (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst(rst),
        .command_req(command_req),
        .command_ack(command_ack),
        .command_kind(command_kind),
        .command_word(command_word),
        .display_clock(display_clock),
        .display_hsync(display_hsync),
        .display_vsync(display_vsync),
        .display_y(display_y),
        .display_cb(display_cb),
        .display_cr(display_cr)
    );

endmodule

//--- design/display_driver.sv
`timescale 1ns/1ns

module display_driver #(
    parameter int H_ACTIVE = 256,
    parameter int H_FRONT = 16,
    parameter int H_SYNC = 32,
    parameter int H_BACK = 16,
    parameter int V_ACTIVE = 192,
    parameter int V_FRONT = 4,
    parameter int V_SYNC = 4,
    parameter int V_BACK = 12
) (
    input logic clock_18MHz_oscillator,
    input logic rst,

    input logic command_req,
    output logic command_ack,
    input display_pkg::command_kind_t command_kind,
    input display_pkg::command_word_t command_word,

    output logic display_clock,
    output logic display_hsync,
    output logic display_vsync,
    output logic [display_pkg::Y_WIDTH-1:0] display_y,
    output logic [display_pkg::CB_WIDTH-1:0] display_cb,
    output logic [display_pkg::CR_WIDTH-1:0] display_cr
);

    import display_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

    logic [$clog2(H_TOTAL)-1:0] h_count;
    logic [$clog2(V_TOTAL)-1:0] v_count;

    // Pending values wait here for the next frame
    logic [Y_WIDTH-1:0] pending_y, fill_y;
    logic [CB_WIDTH-1:0] pending_cb, fill_cb;
    logic [CR_WIDTH-1:0] pending_cr, fill_cr;
    logic [7:0] pending_cursor_x, cursor_x;
    logic [7:0] pending_cursor_y, cursor_y;

    logic active_area;
    logic at_cursor;
    logic frame_end;

    // Ack side of the four-phase link
    always_ff @(posedge clock_18MHz_oscillator) begin
        if (rst) begin
            command_ack <= 1'b0;
        end else if (command_req && !command_ack) begin
            command_ack <= 1'b1;
        end else if (!command_req && command_ack) begin
            command_ack <= 1'b0;
        end
    end

    always_ff @(posedge clock_18MHz_oscillator) begin
        if (rst) begin
            pending_y <= '0;
            pending_cb <= '0;
            pending_cr <= '0;
            pending_cursor_x <= '0;
            pending_cursor_y <= '0;
        end else if (command_req && !command_ack) begin
            if (command_kind == COMMAND_FILL_COLOR) begin
                pending_y <= command_word.color.y;
                pending_cb <= command_word.color.cb;
                pending_cr <= command_word.color.cr;
            end else begin
                pending_cursor_x <= command_word.position.x;
                pending_cursor_y <= command_word.position.y;
            end
        end
    end

    assign active_area = (h_count < H_ACTIVE) && (v_count < V_ACTIVE);
    assign at_cursor = (h_count == cursor_x) && (v_count == cursor_y);
    assign frame_end = (h_count == H_TOTAL - 1) && (v_count == V_TOTAL - 1);

    // One pixel per display clock period, outputs one step behind the counters
    always_ff @(posedge clock_18MHz_oscillator) begin
        if (rst) begin
            display_clock <= 1'b0;
            display_hsync <= 1'b1;
            display_vsync <= 1'b1;
            display_y <= '0;
            display_cb <= '0;
            display_cr <= '0;
            h_count <= '0;
            v_count <= '0;
            fill_y <= '0;
            fill_cb <= '0;
            fill_cr <= '0;
            cursor_x <= '0;
            cursor_y <= '0;
        end else begin
            display_clock <= ~display_clock;
            if (display_clock) begin
                display_hsync <= !(h_count >= H_SYNC_START && h_count < H_SYNC_START + H_SYNC);
                display_vsync <= !(v_count >= V_SYNC_START && v_count < V_SYNC_START + V_SYNC);

                if (!active_area) begin
                    display_y <= '0;    // Blanking
                    display_cb <= '0;
                    display_cr <= '0;
                end else if (at_cursor) begin
                    display_y <= CURSOR_Y;
                    display_cb <= CURSOR_CB;
                    display_cr <= CURSOR_CR;
                end else begin
                    display_y <= fill_y;
                    display_cb <= fill_cb;
                    display_cr <= fill_cr;
                end

                if (h_count == H_TOTAL - 1) begin
                    h_count <= '0;
                    if (v_count == V_TOTAL - 1) v_count <= '0;
                    else v_count <= v_count + 1'b1;
                end else begin
                    h_count <= h_count + 1'b1;
                end

                // Next step draws pixel 0,0 with the new values
                if (frame_end) begin
                    fill_y <= pending_y;
                    fill_cb <= pending_cb;
                    fill_cr <= pending_cr;
                    cursor_x <= pending_cursor_x;
                    cursor_y <= pending_cursor_y;
                end
            end
        end
    end

endmodule

//--- design/graphics_command.sv
`timescale 1ns/1ns

module graphics_command (
    input logic clock_18MHz_oscillator,
    input logic rst,

    input logic [7:0] opcode,
    input logic opcode_valid,
    input logic [7:0] operand,
    input logic operand_valid,
    input logic [7:0] operand_count,

    output logic command_req,
    input logic command_ack,
    output display_pkg::command_kind_t command_kind,
    output display_pkg::command_word_t command_word
);

    import spi_pkg::*;
    import display_pkg::*;

    logic is_graphics;          // Current transaction carries a graphics opcode
    command_kind_t opcode_kind;
    logic [7:0] first_operand;
    logic handshake_open;
    logic command_start;

    // Open from req rising until ack has dropped again
    assign handshake_open = command_req | command_ack;

    assign command_start = operand_valid && is_graphics &&
                           operand_count == 8'd1 && !handshake_open;

    always_ff @(posedge clock_18MHz_oscillator) begin
        if (rst) begin
            is_graphics <= 1'b0;
        end else if (opcode_valid) begin
            is_graphics <= (opcode == OPCODE_FILL_COLOR) || (opcode == OPCODE_CURSOR_POS);
        end
    end

    always_ff @(posedge clock_18MHz_oscillator) begin
        if (opcode_valid) begin
            opcode_kind <= (opcode == OPCODE_CURSOR_POS) ? COMMAND_CURSOR_POS
                                                         : COMMAND_FILL_COLOR;
        end
        if (operand_valid && operand_count == 8'd0) first_operand <= operand;
    end

    // Request side of the four-phase link
    always_ff @(posedge clock_18MHz_oscillator) begin
        if (rst) begin
            command_req <= 1'b0;
        end else if (command_req && command_ack) begin
            command_req <= 1'b0;
        end else if (command_start) begin
            command_req <= 1'b1;
        end
    end

    // Held stable for the whole handshake
    always_ff @(posedge clock_18MHz_oscillator) begin
        if (command_start) begin
            command_kind <= opcode_kind;
            command_word <= {first_operand, operand};
        end
    end

endmodule

//--- design/spi_register.sv
`timescale 1ns/1ns

module spi_register #(
    parameter logic [7:0] REGISTER_OPCODE = 8'h00,
    parameter logic [7:0] REGISTER_VALUE = 8'h00
) (
    input logic clock_18MHz_oscillator,
    input logic rst,

    input logic [7:0] opcode,
    input logic opcode_valid,
    input logic spi_select,

    output logic [7:0] response,
    output logic response_valid
);

    logic [1:0] select_sync;    // Same depth as the peripheral sync

    always_ff @(posedge clock_18MHz_oscillator) begin
        if (rst) begin
            select_sync <= 2'b11;
            response_valid <= 1'b0;
        end else begin
            select_sync <= {select_sync[0], spi_select};
            if (select_sync[1]) begin
                response_valid <= 1'b0;     // Transaction over
            end else if (opcode_valid && opcode == REGISTER_OPCODE) begin
                response_valid <= 1'b1;
            end
        end
    end

    // Zero when idle so the top can OR all registers together
    assign response = response_valid ? REGISTER_VALUE : 8'h00;

endmodule

//--- design/spi_peripheral.sv
`timescale 1ns/1ns

module spi_peripheral (
    input logic clock_18MHz_oscillator,
    input logic rst,

    input logic spi_select,
    input logic spi_clock,
    input logic spi_data_in,
    output logic spi_data_out,

    output logic [7:0] opcode,
    output logic opcode_valid,
    output logic [7:0] operand,
    output logic operand_valid,
    output logic [7:0] operand_count,

    input logic [7:0] response,
    input logic response_valid
);

    // Bit 0 is the first stage, bit 1 the synced value, bit 2 the previous one
    logic [2:0] select_sync;
    logic [2:0] clock_sync;
    logic [1:0] data_sync;

    logic selected;
    logic select_rise;
    logic clock_rise;
    logic clock_fall;

    logic [2:0] bit_count;
    logic [7:0] byte_index;     // 0 while the opcode byte is coming in
    logic [6:0] shift_in;
    logic [7:0] received;
    logic [6:0] shift_out;      // Bits still to send after the current one

    always_ff @(posedge clock_18MHz_oscillator) begin
        if (rst) begin
            select_sync <= 3'b111;
            clock_sync <= '0;
            data_sync <= '0;
        end else begin
            select_sync <= {select_sync[1:0], spi_select};
            clock_sync <= {clock_sync[1:0], spi_clock};
            data_sync <= {data_sync[0], spi_data_in};
        end
    end

    assign selected = ~select_sync[1];
    assign select_rise = select_sync[1] & ~select_sync[2];
    assign clock_rise = clock_sync[1] & ~clock_sync[2];
    assign clock_fall = ~clock_sync[1] & clock_sync[2];

    assign received = {shift_in, data_sync[1]};

    // Receive side, sample on rising SPI clock
    always_ff @(posedge clock_18MHz_oscillator) begin
        opcode_valid <= 1'b0;
        operand_valid <= 1'b0;
        if (rst) begin
            bit_count <= '0;
            byte_index <= '0;
            operand_count <= '0;
        end else if (!selected) begin
            bit_count <= '0;
            byte_index <= '0;
            if (select_rise) operand_count <= '0;
        end else if (clock_rise) begin
            shift_in <= received[6:0];
            bit_count <= bit_count + 1'b1;
            if (bit_count == 3'd7) begin
                if (byte_index != 8'hFF) byte_index <= byte_index + 1'b1;   // Saturate
                if (byte_index == 8'd0) begin
                    opcode <= received;
                    opcode_valid <= 1'b1;
                end else begin
                    operand <= received;
                    operand_valid <= 1'b1;
                    operand_count <= byte_index - 1'b1;
                end
            end
        end
    end

    // Transmit side, change data on falling SPI clock
    always_ff @(posedge clock_18MHz_oscillator) begin
        if (rst || !selected) begin
            spi_data_out <= 1'b0;
            shift_out <= '0;
        end else if (clock_fall) begin
            if (bit_count == 3'd0) begin
                // A byte just finished so the next one starts here
                spi_data_out <= response_valid ? response[7] : 1'b0;
                shift_out <= response_valid ? response[6:0] : 7'd0;
            end else begin
                spi_data_out <= shift_out[6];
                shift_out <= {shift_out[5:0], 1'b0};
            end
        end
    end

endmodule

//--- design/display_pkg.sv
package display_pkg;

    // Pixel bus widths
    localparam int Y_WIDTH = 4;
    localparam int CB_WIDTH = 3;
    localparam int CR_WIDTH = 3;

    // Which view of the command word applies
    typedef enum logic {
        COMMAND_FILL_COLOR = 1'b0,
        COMMAND_CURSOR_POS = 1'b1
    } command_kind_t;

    // Two operand bytes, first operand in the high byte
    typedef union packed {
        struct packed {
            logic [Y_WIDTH-1:0] y;
            logic [CB_WIDTH-1:0] cb;
            logic [CR_WIDTH-1:0] cr;
            logic [5:0] unused;     // Low bits of second operand
        } color;
        struct packed {
            logic [7:0] x;
            logic [7:0] y;
        } position;
    } command_word_t;

    // Cursor is always drawn in this colour
    localparam logic [Y_WIDTH-1:0] CURSOR_Y = 4'd15;
    localparam logic [CB_WIDTH-1:0] CURSOR_CB = 3'd4;
    localparam logic [CR_WIDTH-1:0] CURSOR_CR = 3'd4;

endpackage

//--- design/spi_pkg.sv
package spi_pkg;

    // Register reads, the opcode doubles as the register address
    localparam logic [7:0] OPCODE_CHIP_ID = 8'hDB;
    localparam logic [7:0] OPCODE_VERSION = 8'hDC;

    // Graphics opcodes
    // Both are followed by two operand bytes, high byte first
    localparam logic [7:0] OPCODE_FILL_COLOR = 8'h10;
    localparam logic [7:0] OPCODE_CURSOR_POS = 8'h11;

    // Default register contents
    localparam logic [7:0] CHIP_ID_VALUE = 8'h81;
    localparam logic [7:0] VERSION_VALUE = 8'h02;   // Bumped on each design release

endpackage
